//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/1ps
TOP       = tb_lagd
FILELIST  = sim.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf $(OBJDIR)

//--- design/galena_array.sv
`timescale 1ns/1ps

module galena_array (
    input  logic               feedback_i,
    input  logic               reset_i,
    input  lagd_pkg::bus_req_t bus_i,
    output lagd_pkg::wbl_t     wbl_read_o,
    output lagd_pkg::spin_t    bct_read_o
);
    import lagd_pkg::*;

    wbl_t     weight_mem [WWL_WIDTH];  // coupling weights, one word per row
    spin_t    spin_cache;
    lat_cnt_t fb_cnt;                  // cycles since feedback rose, saturating

    logic rd_en;
    logic wr_en;
    logic load_en;
    logic fb_on;
    logic fb_ready;

    assign rd_en    = &bus_i.wbl_floating;   // all lines floating -> sense
    assign wr_en    = ~|bus_i.wbl_floating;  // all lines driven -> write
    assign load_en  = &bus_i.write_spin;
    assign fb_on    = |bus_i.feedback;
    assign fb_ready = (fb_cnt == lat_cnt_t'(SPIN_LATENCY));

    // ========================================
    // weight array
    // ========================================
    always_ff @(posedge feedback_i) begin
        for (int i = 0; i < WWL_WIDTH; i++) begin
            if (bus_i.wwl[i] && wr_en) begin
                weight_mem[i] <= bus_i.wbl;
            end
        end
    end

    // row readout is combinational, zero when no read is selected
    always_comb begin
        wbl_read_o = '0;
        for (int i = 0; i < WWL_WIDTH; i++) begin
            if (bus_i.wwl[i] && rd_en) begin
                wbl_read_o = weight_mem[i];
            end
        end
    end

    // ========================================
    // spin cache and readout
    // ========================================
    always_ff @(posedge feedback_i) begin
        if (load_en) begin
            for (int i = 0; i < NUM_SPIN; i++) begin
                spin_cache[i] <= bus_i.wbl[BIT_DATA*i + SPIN_WBL_OFFSET];  // one lane per group
            end
        end
    end

    // fixed stand-in for the analog settle delay
    always_ff @(posedge feedback_i) begin
        if (reset_i) begin
            fb_cnt <= '0;
        end else if (!fb_on) begin
            fb_cnt <= '0;                        // restart on every new pulse
        end else if (!fb_ready) begin
            fb_cnt <= fb_cnt + lat_cnt_t'(1);
        end
    end

    // readout holds only while the spin's own strobe stays high
    assign bct_read_o = fb_ready ? (spin_cache & bus_i.feedback) : '0;

    // at most one row selected per cycle
    a_wwl_onehot: assert property (@(posedge feedback_i) disable iff (reset_i)
        $onehot0(bus_i.wwl));

    // row access and spin load share the bit lines, so they never overlap
    a_wwl_vs_spin: assert property (@(posedge feedback_i) disable iff (reset_i)
        !((|bus_i.wwl) && (|bus_i.write_spin)));

endmodule

//--- design/lagd_pkg.sv
package lagd_pkg;

    // ========================================
    // macro geometry
    // ========================================
    localparam int WBL_WIDTH       = 32;  // bit lines
    localparam int WWL_WIDTH       = 8;   // weight rows
    localparam int NUM_SPIN        = 8;
    localparam int BIT_DATA        = 4;   // bit lines per spin group
    localparam int SPIN_WBL_OFFSET = 0;   // lane inside a group that carries the spin

    // settle time of the spin readout, counted from the feedback rise
    localparam int SPIN_LATENCY    = 3;

    // queue depth per port, equal to the host credit count
    localparam int PORT_CREDITS    = 2;

    localparam int ROW_W  = $clog2(WWL_WIDTH);
    localparam int LAT_W  = $clog2(SPIN_LATENCY + 1);
    localparam int QPTR_W = (PORT_CREDITS > 1) ? $clog2(PORT_CREDITS) : 1;
    localparam int QCNT_W = $clog2(PORT_CREDITS + 1);

    // arbiter request slots
    localparam int WEIGHT_IDX = 0;
    localparam int SPIN_IDX   = 1;

    // ========================================
    // plain vector types
    // ========================================
    typedef logic [WBL_WIDTH-1:0] wbl_t;     // one bit-line word
    typedef logic [WWL_WIDTH-1:0] wwl_t;     // one-hot row select
    typedef logic [ROW_W-1:0]     row_t;     // row index
    typedef logic [NUM_SPIN-1:0]  spin_t;    // one bit per spin
    typedef logic [LAT_W-1:0]     lat_cnt_t; // feedback settle counter
    typedef logic [QPTR_W-1:0]    qptr_t;    // queue pointer
    typedef logic [QCNT_W-1:0]    qcnt_t;    // queue fill level

    // ========================================
    // channel structs
    // ========================================
    typedef struct packed {
        logic write;  // 1 = row write, 0 = row read
        row_t row;
        wbl_t data;   // ignored on reads
    } weight_cmd_t;

    typedef struct packed {
        spin_t spins;
    } spin_cmd_t;

    // macro bus, lane controls are per bit line / per spin as on the macro pins
    typedef struct packed {
        wbl_t  wbl;
        wwl_t  wwl;
        wbl_t  wbl_floating;  // all ones selects a read
        spin_t write_spin;    // all ones loads the spin cache
        spin_t feedback;      // per-spin feedback strobe
    } bus_req_t;

    typedef struct packed {
        row_t row;
        wbl_t data;
    } weight_rsp_t;

    typedef struct packed {
        spin_t spins;
    } spin_rsp_t;

    localparam bus_req_t BUS_IDLE = '0;  // nothing selected, nothing driven

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WEIGHT,
        ARB_SPIN
    } arb_state_t;

    typedef enum logic [2:0] {
        SP_IDLE,
        SP_LOAD,
        SP_PULSE,
        SP_WAIT,
        SP_DONE
    } spin_state_t;

endpackage

//--- design/lagd_top.sv
`timescale 1ns/1ps

module lagd_top (
    input  logic                  feedback_i,
    input  logic                  reset_i,
    input  logic                  wcmd_valid_i,
    input  lagd_pkg::weight_cmd_t wcmd_i,
    input  logic                  scmd_valid_i,
    input  lagd_pkg::spin_cmd_t   scmd_i,
    output logic                  wcmd_credit_o,
    output logic                  wrsp_valid_o,
    output lagd_pkg::weight_rsp_t wrsp_o,
    output logic                  scmd_credit_o,
    output logic                  srsp_valid_o,
    output lagd_pkg::spin_rsp_t   srsp_o
);
    import lagd_pkg::*;

    logic [1:0]     req;
    logic [1:0]     gnt;
    bus_req_t [1:0] port_bus;   // per-port requests into the arbiter
    bus_req_t       macro_bus;  // what the macro sees
    wbl_t           wbl_read;
    spin_t          bct_read;

    // ========================================
    // host ports
    // ========================================
    weight_port weight_port_inst (
        .feedback_i  (feedback_i),
        .reset_i     (reset_i),
        .cmd_valid_i (wcmd_valid_i),
        .cmd_i       (wcmd_i),
        .credit_o    (wcmd_credit_o),
        .req_o       (req[WEIGHT_IDX]),
        .gnt_i       (gnt[WEIGHT_IDX]),
        .bus_o       (port_bus[WEIGHT_IDX]),
        .rd_data_i   (wbl_read),          // readout goes to both, only the owner samples
        .rsp_valid_o (wrsp_valid_o),
        .rsp_o       (wrsp_o)
    );

    spin_port spin_port_inst (
        .feedback_i  (feedback_i),
        .reset_i     (reset_i),
        .cmd_valid_i (scmd_valid_i),
        .cmd_i       (scmd_i),
        .credit_o    (scmd_credit_o),
        .req_o       (req[SPIN_IDX]),
        .gnt_i       (gnt[SPIN_IDX]),
        .bus_o       (port_bus[SPIN_IDX]),
        .bct_i       (bct_read),
        .rsp_valid_o (srsp_valid_o),
        .rsp_o       (srsp_o)
    );

    // ========================================
    // shared bus and macro
    // ========================================
    wbl_arbiter wbl_arbiter_inst (
        .feedback_i (feedback_i),
        .reset_i    (reset_i),
        .req_i      (req),
        .bus_i      (port_bus),
        .gnt_o      (gnt),
        .bus_o      (macro_bus)
    );

    galena_array galena_array_inst (
        .feedback_i (feedback_i),
        .reset_i    (reset_i),
        .bus_i      (macro_bus),
        .wbl_read_o (wbl_read),
        .bct_read_o (bct_read)
    );

endmodule

//--- design/spin_port.sv
`timescale 1ns/1ps

module spin_port (
    input  logic                feedback_i,
    input  logic                reset_i,
    input  logic                cmd_valid_i,
    input  lagd_pkg::spin_cmd_t cmd_i,
    output logic                credit_o,
    output logic                req_o,
    input  logic                gnt_i,
    output lagd_pkg::bus_req_t  bus_o,
    input  lagd_pkg::spin_t     bct_i,
    output logic                rsp_valid_o,
    output lagd_pkg::spin_rsp_t rsp_o
);
    import lagd_pkg::*;

    spin_cmd_t   queue [PORT_CREDITS];
    qptr_t       wr_ptr;
    qptr_t       rd_ptr;
    qcnt_t       count;
    spin_state_t state_q;
    lat_cnt_t    wait_cnt;
    spin_t       cur_spins;   // vector of the running command
    wbl_t        wbl_exp;
    logic        empty;
    logic        pop;
    logic        busy;
    logic        capture;

    assign empty   = (count == '0);
    assign busy    = (state_q == SP_LOAD) || (state_q == SP_PULSE) || (state_q == SP_WAIT);
    assign req_o   = busy || (state_q == SP_IDLE && !empty);  // held across the sequence
    assign pop     = gnt_i && (state_q == SP_IDLE) && !empty;
    assign capture = (state_q == SP_WAIT) && (wait_cnt == lat_cnt_t'(SPIN_LATENCY - 1));

    always_ff @(posedge feedback_i) begin
        if (cmd_valid_i) begin
            queue[wr_ptr] <= cmd_i;
        end
    end

    // ========================================
    // queue pointers and sequencer
    // ========================================
    always_ff @(posedge feedback_i) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credit_o    <= 1'b0;
            state_q     <= SP_IDLE;
            wait_cnt    <= '0;
            rsp_valid_o <= 1'b0;
        end else begin
            credit_o    <= pop;
            rsp_valid_o <= capture;  // response one cycle after the capture edge
            if (cmd_valid_i) begin
                wr_ptr <= (wr_ptr == qptr_t'(PORT_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == qptr_t'(PORT_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (cmd_valid_i && !pop) begin
                count <= count + qcnt_t'(1);
            end else if (!cmd_valid_i && pop) begin
                count <= count - qcnt_t'(1);
            end
            case (state_q)
                SP_IDLE:  if (pop) state_q <= SP_LOAD;
                SP_LOAD:  state_q <= SP_PULSE;              // write_spin for one cycle
                SP_PULSE: begin
                    wait_cnt <= '0;
                    state_q  <= SP_WAIT;
                end
                SP_WAIT:  begin
                    if (capture) begin
                        state_q <= SP_DONE;
                    end else begin
                        wait_cnt <= wait_cnt + lat_cnt_t'(1);
                    end
                end
                SP_DONE:  state_q <= SP_IDLE;               // req low, bus released
                default:  state_q <= SP_IDLE;
            endcase
        end
    end

    always_ff @(posedge feedback_i) begin
        if (pop) cur_spins <= queue[rd_ptr].spins;
        if (capture) rsp_o.spins <= bct_i;          // last cycle with feedback high
    end

    // spin i sits on lane BIT_DATA*i + SPIN_WBL_OFFSET, other lanes low
    always_comb begin
        wbl_exp = '0;
        for (int i = 0; i < NUM_SPIN; i++) begin
            wbl_exp[BIT_DATA*i + SPIN_WBL_OFFSET] = cur_spins[i];
        end
    end

    always_comb begin
        bus_o = BUS_IDLE;
        if (busy) bus_o.wbl = wbl_exp;
        if (state_q == SP_LOAD) bus_o.write_spin = '1;
        if (state_q == SP_PULSE || state_q == SP_WAIT) bus_o.feedback = '1;  // latency + 1 cycles
    end

    // the arbiter must not take the bus away in mid sequence
    a_gnt_held: assert property (@(posedge feedback_i) disable iff (reset_i)
        busy |-> gnt_i);

endmodule

//--- design/wbl_arbiter.sv
`timescale 1ns/1ps

module wbl_arbiter (
    input  logic                     feedback_i,
    input  logic                     reset_i,
    input  logic [1:0]               req_i,
    input  lagd_pkg::bus_req_t [1:0] bus_i,
    output logic [1:0]               gnt_o,
    output lagd_pkg::bus_req_t       bus_o
);
    import lagd_pkg::*;

    arb_state_t state_q;
    arb_state_t state_d;
    logic       last_q;  // last winner is 0 for weight and 1 for spin

    // ========================================
    // owner selection
    // ========================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ARB_IDLE: begin
                if (req_i[WEIGHT_IDX] && req_i[SPIN_IDX]) begin
                    state_d = last_q ? ARB_WEIGHT : ARB_SPIN;  // tie goes to the other one
                end else if (req_i[WEIGHT_IDX]) begin
                    state_d = ARB_WEIGHT;
                end else if (req_i[SPIN_IDX]) begin
                    state_d = ARB_SPIN;
                end
            end
            ARB_WEIGHT: if (!req_i[WEIGHT_IDX]) state_d = req_i[SPIN_IDX] ? ARB_SPIN : ARB_IDLE;
            ARB_SPIN:   if (!req_i[SPIN_IDX]) state_d = req_i[WEIGHT_IDX] ? ARB_WEIGHT : ARB_IDLE;
            default:    state_d = ARB_IDLE;
        endcase
    end

    always_ff @(posedge feedback_i) begin
        if (reset_i) begin
            state_q <= ARB_IDLE;
            last_q  <= 1'b1;                   // weight port wins the first tie
        end else begin
            state_q <= state_d;
            if (state_d == ARB_WEIGHT) last_q <= 1'b0;
            if (state_d == ARB_SPIN) last_q <= 1'b1;
        end
    end

    // grant only while the owner still asks
    assign gnt_o[WEIGHT_IDX] = (state_q == ARB_WEIGHT) && req_i[WEIGHT_IDX];
    assign gnt_o[SPIN_IDX]   = (state_q == ARB_SPIN) && req_i[SPIN_IDX];

    always_comb begin
        bus_o = BUS_IDLE;
        if (gnt_o[WEIGHT_IDX]) begin
            bus_o = bus_i[WEIGHT_IDX];
        end else if (gnt_o[SPIN_IDX]) begin
            bus_o = bus_i[SPIN_IDX];
        end
    end

    // a port that waits for its grant keeps its request and its bus word
    a_weight_req_held: assert property (@(posedge feedback_i) disable iff (reset_i)
        req_i[WEIGHT_IDX] && !gnt_o[WEIGHT_IDX] |=>
            req_i[WEIGHT_IDX] && $stable(bus_i[WEIGHT_IDX]));

    a_spin_req_held: assert property (@(posedge feedback_i) disable iff (reset_i)
        req_i[SPIN_IDX] && !gnt_o[SPIN_IDX] |=>
            req_i[SPIN_IDX] && $stable(bus_i[SPIN_IDX]));

endmodule

//--- design/weight_port.sv
`timescale 1ns/1ps

module weight_port (
    input  logic                  feedback_i,
    input  logic                  reset_i,
    input  logic                  cmd_valid_i,
    input  lagd_pkg::weight_cmd_t cmd_i,
    output logic                  credit_o,
    output logic                  req_o,
    input  logic                  gnt_i,
    output lagd_pkg::bus_req_t    bus_o,
    input  lagd_pkg::wbl_t        rd_data_i,
    output logic                  rsp_valid_o,
    output lagd_pkg::weight_rsp_t rsp_o
);
    import lagd_pkg::*;

    weight_cmd_t queue [PORT_CREDITS];
    weight_cmd_t head;
    qptr_t       wr_ptr;
    qptr_t       rd_ptr;
    qcnt_t       count;
    logic        empty;
    logic        pop;
    logic        popped_q;  // one idle cycle after each command lets the spin port in

    assign empty = (count == '0);
    assign head  = queue[rd_ptr];
    assign req_o = !empty && !popped_q;
    assign pop   = gnt_i && req_o;  // a granted cycle executes the head

    // ========================================
    // command queue
    // ========================================
    always_ff @(posedge feedback_i) begin
        if (cmd_valid_i) begin
            queue[wr_ptr] <= cmd_i;
        end
    end

    always_ff @(posedge feedback_i) begin
        if (reset_i) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            credit_o    <= 1'b0;
            popped_q    <= 1'b0;
            rsp_valid_o <= 1'b0;
        end else begin
            credit_o    <= pop;                  // one credit back per pop
            popped_q    <= pop;
            rsp_valid_o <= pop && !head.write;   // reads answer next cycle
            if (cmd_valid_i) begin
                wr_ptr <= (wr_ptr == qptr_t'(PORT_CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == qptr_t'(PORT_CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (cmd_valid_i && !pop) begin
                count <= count + qcnt_t'(1);
            end else if (!cmd_valid_i && pop) begin
                count <= count - qcnt_t'(1);
            end
        end
    end

    // bus follows the head so it stays put until the grant arrives
    always_comb begin
        bus_o = BUS_IDLE;
        if (!empty) begin
            bus_o.wwl = wwl_t'(1) << head.row;
            if (head.write) begin
                bus_o.wbl = head.data;
            end else begin
                bus_o.wbl_floating = '1;         // release lines for sensing
            end
        end
    end

    always_ff @(posedge feedback_i) begin
        if (pop && !head.write) begin
            rsp_o.row  <= head.row;
            rsp_o.data <= rd_data_i;             // sampled in the granted cycle
        end
    end

    // host keeps within its credits
    a_no_overflow: assert property (@(posedge feedback_i) disable iff (reset_i)
        cmd_valid_i |-> (count < qcnt_t'(PORT_CREDITS)) || pop);

endmodule

//--- sim.f
+incdir+sim
design/lagd_pkg.sv
design/galena_array.sv
design/weight_port.sv
design/spin_port.sv
design/wbl_arbiter.sv
design/lagd_top.sv
sim/tb_lagd.sv

//--- sim/tb_lagd_model.svh
`ifndef TB_LAGD_MODEL_SVH
`define TB_LAGD_MODEL_SVH

// shadow of the macro updated in command issue order
wbl_t  shadow [WWL_WIDTH];  // one word per weight row
spin_t last_spin;           // spin cache after the newest spin command

function automatic void store_row(input row_t row, input wbl_t data);
    shadow[row] = data;
endfunction

// a read returns the row index and the last word written there
function automatic weight_rsp_t expected_row(input row_t row);
    weight_rsp_t r;
    r.row  = row;
    r.data = shadow[row];
    return r;
endfunction

// spins go out on one lane per group and the cache loads from the same lane
function automatic spin_rsp_t expected_spins(input spin_t spins);
    wbl_t      lines;
    spin_rsp_t r;
    lines = '0;
    for (int i = 0; i < NUM_SPIN; i++) begin
        lines[BIT_DATA*i + SPIN_WBL_OFFSET] = spins[i];  // lane BIT_DATA*i + offset
    end
    for (int i = 0; i < NUM_SPIN; i++) begin
        last_spin[i] = lines[BIT_DATA*i + SPIN_WBL_OFFSET];
    end
    r.spins = last_spin;  // readout returns the cached spins
    return r;
endfunction

`endif

//--- sim/tb_lagd.sv
`timescale 1ns/1ps

module tb_lagd;
    import lagd_pkg::*;
    `include "tb_lagd_model.svh"

    localparam int TIMEOUT = 200;  // cycles allowed per wait

    logic        feedback;
    logic        reset;
    logic        wcmd_valid;
    weight_cmd_t wcmd;
    logic        scmd_valid;
    spin_cmd_t   scmd;
    logic        wcmd_credit;
    logic        wrsp_valid;
    weight_rsp_t wrsp;
    logic        scmd_credit;
    logic        srsp_valid;
    spin_rsp_t   srsp;

    int          seed;
    logic [31:0] rnd;
    int          errors;
    int          test_err;     // error count when the current test started
    int          tests_run;
    int          tests_failed;
    int          wcredits;     // host side credit counters
    int          scredits;
    int          wcredit_pulses;
    int          scredit_pulses;
    int          p_w;
    int          p_s;
    weight_rsp_t exp_w [$];    // expected responses in order
    spin_rsp_t   exp_s [$];
    weight_rsp_t w_exp;
    spin_rsp_t   s_exp;
    weight_cmd_t mix_w [20];   // mixed traffic drawn before the fork
    spin_t       mix_s [8];
    weight_cmd_t c;

    lagd_top lagd_top_inst (
        .feedback_i    (feedback),
        .reset_i       (reset),
        .wcmd_valid_i  (wcmd_valid),
        .wcmd_i        (wcmd),
        .scmd_valid_i  (scmd_valid),
        .scmd_i        (scmd),
        .wcmd_credit_o (wcmd_credit),
        .wrsp_valid_o  (wrsp_valid),
        .wrsp_o        (wrsp),
        .scmd_credit_o (scmd_credit),
        .srsp_valid_o  (srsp_valid),
        .srsp_o        (srsp)
    );

    always #2 feedback = ~feedback;  // 4 ns period

    // ========================================
    // response and credit monitor on the falling edge
    // ========================================
    always @(negedge feedback) begin
        if (!reset) begin
            if (wcmd_credit) begin
                wcredits++;
                wcredit_pulses++;
            end
            if (scmd_credit) begin
                scredits++;
                scredit_pulses++;
            end
            if (wcredits > PORT_CREDITS || scredits > PORT_CREDITS) begin
                $display("a credit came back with no command outstanding");
                errors++;
            end
            if (wrsp_valid) begin
                if (exp_w.size() == 0) begin
                    $display("a weight response arrived with none expected");
                    errors++;
                end else begin
                    w_exp = exp_w.pop_front();
                    if (wrsp !== w_exp) begin
                        $display("[ERROR] wrsp_o expected %h got %h", w_exp, wrsp);
                        errors++;
                    end
                end
            end
            if (srsp_valid) begin
                if (exp_s.size() == 0) begin
                    $display("a spin response arrived with none expected");
                    errors++;
                end else begin
                    s_exp = exp_s.pop_front();
                    if (srsp !== s_exp) begin
                        $display("[ERROR] srsp_o expected %h got %h", s_exp, srsp);
                        errors++;
                    end
                end
            end
        end
    end

    // ========================================
    // host tasks called 0.5 ns after a rising edge
    // ========================================
    task automatic send_weight(input weight_cmd_t cmd);
        int t;
        t = 0;
        while (wcredits == 0 && t < TIMEOUT) begin  // hold off without a credit
            @(posedge feedback);
            #0.5;
            t++;
        end
        if (wcredits == 0) begin
            $display("timed out waiting for a weight credit");
            errors++;
        end else begin
            wcredits--;
            if (cmd.write) store_row(cmd.row, cmd.data);
            else exp_w.push_back(expected_row(cmd.row));
            wcmd       = cmd;
            wcmd_valid = 1'b1;
            @(posedge feedback);
            #0.5;
            wcmd_valid = 1'b0;
        end
    endtask

    task automatic send_spin(input spin_t spins);
        int t;
        t = 0;
        while (scredits == 0 && t < TIMEOUT) begin
            @(posedge feedback);
            #0.5;
            t++;
        end
        if (scredits == 0) begin
            $display("timed out waiting for a spin credit");
            errors++;
        end else begin
            scredits--;
            exp_s.push_back(expected_spins(spins));
            scmd.spins = spins;
            scmd_valid = 1'b1;
            @(posedge feedback);
            #0.5;
            scmd_valid = 1'b0;
        end
    endtask

    function automatic bit all_idle();
        return exp_w.size() == 0 && exp_s.size() == 0 &&
               wcredits == PORT_CREDITS && scredits == PORT_CREDITS;
    endfunction

    // all responses in and all credits home
    task automatic wait_idle();
        int t;
        t = 0;
        while (!all_idle() && t < TIMEOUT) begin
            @(posedge feedback);
            #0.5;
            t++;
        end
        if (!all_idle()) begin
            $display("timed out waiting for outstanding responses and credits");
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors != test_err) tests_failed++;
        $display("test %s done, %0d errors", name, errors - test_err);
        test_err = errors;
    endtask

    // ========================================
    // test sequence
    // ========================================
    initial begin
        feedback       = 1'b0;
        reset          = 1'b1;
        wcmd_valid     = 1'b0;
        wcmd           = '0;
        scmd_valid     = 1'b0;
        scmd           = '0;
        seed           = 32'h57b1_daab;
        errors         = 0;
        test_err       = 0;
        tests_run      = 0;
        tests_failed   = 0;
        wcredits       = PORT_CREDITS;
        scredits       = PORT_CREDITS;
        wcredit_pulses = 0;
        scredit_pulses = 0;
        repeat (8) @(posedge feedback);
        #0.5;
        reset = 1'b0;

        // quiet after reset
        for (int k = 0; k < 20; k++) begin
            @(negedge feedback);
            if (wcmd_credit || wrsp_valid || scmd_credit || srsp_valid) begin
                $display("a valid or credit pulse appeared with no command sent");
                errors++;
            end
        end
        @(posedge feedback);
        #0.5;
        finish_test("idle");

        // first pass covers every row and later passes pick random rows
        for (int k = 0; k < 40; k++) begin
            rnd     = $random(seed);
            c.write = 1'b1;
            c.row   = (k < WWL_WIDTH) ? row_t'(k) : rnd[ROW_W-1:0];
            c.data  = $random(seed);
            send_weight(c);
        end
        for (int k = 0; k < WWL_WIDTH; k++) begin
            c.write = 1'b0;
            c.row   = row_t'(k);
            c.data  = '0;
            send_weight(c);
        end
        wait_idle();
        finish_test("weight");

        for (int k = 0; k < 12; k++) begin
            rnd = $random(seed);
            send_spin(rnd[NUM_SPIN-1:0]);
        end
        wait_idle();
        finish_test("spin");

        // back to back up to the credit limit
        p_w = wcredit_pulses;
        p_s = scredit_pulses;
        for (int k = 0; k < PORT_CREDITS; k++) begin
            c.write = 1'b1;
            c.row   = row_t'(k);
            c.data  = $random(seed);
            send_weight(c);
        end
        for (int k = 0; k < PORT_CREDITS; k++) begin
            rnd = $random(seed);
            send_spin(rnd[NUM_SPIN-1:0]);
        end
        wait_idle();
        if (wcredit_pulses - p_w != PORT_CREDITS) begin
            $display("[ERROR] wcmd_credit_o pulses expected %h got %h",
                     PORT_CREDITS, wcredit_pulses - p_w);
            errors++;
        end
        if (scredit_pulses - p_s != PORT_CREDITS) begin
            $display("[ERROR] scmd_credit_o pulses expected %h got %h",
                     PORT_CREDITS, scredit_pulses - p_s);
            errors++;
        end
        finish_test("credit");

        // both ports at once so the arbiter interleaves them
        for (int k = 0; k < 20; k++) begin
            rnd             = $random(seed);
            mix_w[k].write  = rnd[0];
            mix_w[k].row    = rnd[ROW_W:1];
            mix_w[k].data   = $random(seed);
        end
        for (int k = 0; k < 8; k++) begin
            rnd      = $random(seed);
            mix_s[k] = rnd[NUM_SPIN-1:0];
        end
        fork
            for (int k = 0; k < 20; k++) begin
                send_weight(mix_w[k]);
            end
            for (int k = 0; k < 8; k++) begin
                send_spin(mix_s[k]);
            end
        join
        wait_idle();
        finish_test("mixed");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
